// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_adc_capture
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== capture/capture_buffer.sv ====
module capture_buffer #(
	parameter int DEPTH_LOG2 = 10
) (
	input  logic                          data_clk_div,
	input  logic                          rst,
	input  logic                          capture_en,
	input  adc_capture_pkg::sample_t      ch0,
	input  adc_capture_pkg::sample_t      ch1,
	input  logic [DEPTH_LOG2-1:0]         mem_addr,
	output adc_capture_pkg::sample_pair_t mem_data,
	output logic                          capture_done
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	adc_capture_pkg::sample_pair_t mem [DEPTH];
	adc_capture_pkg::sample_pair_t wr_pair;
	logic [DEPTH_LOG2-1:0]         wr_addr;
	logic                          en_q;
	logic                          capturing;
	logic                          start;

	assign start = capture_en & ~en_q;
	assign wr_pair.ch0 = ch0;
	assign wr_pair.ch1 = ch1;

	always_ff @(posedge data_clk_div) begin
		if (rst) begin
			en_q <= 1'b0;
			capturing <= 1'b0;
			capture_done <= 1'b0;
			wr_addr <= '0;
		end else begin
			en_q <= capture_en;
			if (!capture_en) begin
				capturing <= 1'b0;
				capture_done <= 1'b0;
			end else if (start) begin
				capturing <= 1'b1;
				capture_done <= 1'b0;
				wr_addr <= '0;
			end else if (capturing) begin
				wr_addr <= wr_addr + 1'b1;
				// last word written, stop
				if (wr_addr == '1) begin
					capturing <= 1'b0;
					capture_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (capturing) begin
			mem[wr_addr] <= wr_pair;
		end
		mem_data <= mem[mem_addr];
	end

endmodule

// ==== capture/wb_ctrl.sv ====
module wb_ctrl #(
	parameter int DEPTH_LOG2 = 10
) (
	input  logic                          data_clk_div,
	input  logic                          rst,
	input  adc_capture_pkg::wb_req_t      wb_req,
	output adc_capture_pkg::wb_rsp_t      wb_rsp,
	input  adc_capture_pkg::slip_t        slip,
	input  logic                          frame_valid,
	input  logic                          capture_done,
	input  adc_capture_pkg::sample_pair_t mem_data,
	output logic                          capture_en,
	output logic                          align_en,
	output logic [DEPTH_LOG2-1:0]         mem_addr
);

	adc_capture_pkg::wb_data_t reg_rd;
	adc_capture_pkg::wb_data_t rd_dat;
	logic [1:0]                ctrl;
	logic                      req;
	logic                      accept;
	logic                      is_mem;
	logic                      ack;
	logic                      rd_mem;

	assign req = wb_req.cyc & wb_req.stb;
	// new request, not yet acknowledged
	assign accept = req & ~ack;
	assign is_mem = wb_req.adr[adc_capture_pkg::MEM_SEL_BIT];
	assign mem_addr = wb_req.adr[DEPTH_LOG2-1:0];

	assign capture_en = ctrl[0];
	assign align_en = ctrl[1];

	always_comb begin
		reg_rd = '0;
		if (wb_req.adr == adc_capture_pkg::REG_CTRL) begin
			reg_rd[1:0] = ctrl;
		end else if (wb_req.adr == adc_capture_pkg::REG_STATUS) begin
			reg_rd[2:0] = slip;
			reg_rd[4] = frame_valid;
			reg_rd[5] = capture_done;
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (rst) begin
			ack <= 1'b0;
			rd_mem <= 1'b0;
			ctrl <= '0;
		end else begin
			ack <= accept;
			if (accept) begin
				rd_mem <= is_mem;
				// memory region writes are dropped
				if (wb_req.we && !is_mem && wb_req.adr == adc_capture_pkg::REG_CTRL) begin
					ctrl <= wb_req.dat[1:0];
				end
			end
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (accept) begin
			rd_dat <= reg_rd;
		end
	end

	// memory word arrives one cycle after the address, same edge as ack
	always_comb begin
		wb_rsp.ack = ack;
		if (rd_mem) begin
			wb_rsp.dat = adc_capture_pkg::wb_data_t'(mem_data);
		end else begin
			wb_rsp.dat = rd_dat;
		end
	end

endmodule

// ==== common/adc_capture_pkg.sv ====
package adc_capture_pkg;

	typedef logic [7:0] raw_word_t;
	typedef logic [2:0] slip_t;
	typedef logic [15:0] sample_t;
	typedef logic [11:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;

	typedef struct packed {
		sample_t ch0;
		sample_t ch1;
	} sample_pair_t;

	// the two serial lanes of one adc channel
	typedef struct packed {
		raw_word_t lane_a;
		raw_word_t lane_b;
	} lane_pair_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		wb_data_t dat;
	} wb_req_t;

	typedef struct packed {
		logic     ack;
		wb_data_t dat;
	} wb_rsp_t;

	typedef enum logic {
		SEARCH,
		LOCKED
	} align_state_t;

	localparam raw_word_t FRAME_PATTERN = 8'hF0;
	localparam int LOCK_COUNT = 4;

	// register map, word addresses
	localparam wb_addr_t REG_CTRL = 12'd0;
	localparam wb_addr_t REG_STATUS = 12'd1;
	localparam int MEM_SEL_BIT = 11;

	// rotate one raw word right by the bit-slip amount
	function automatic raw_word_t rot_right(raw_word_t w, slip_t s);
		logic [15:0] dbl;
		dbl = {w, w} >> s;
		return dbl[7:0];
	endfunction

endpackage

// ==== compile.f ====
common/adc_capture_pkg.sv
frame_align/frame_aligner.sv
rtl/sample_lane.sv
capture/capture_buffer.sv
capture/wb_ctrl.sv
rtl/adc_capture_top.sv
tb/adc_capture_asserts.sv
tb/adc_checker.sv
tb/tb_adc_capture.sv

// ==== frame_align/frame_aligner.sv ====
module frame_aligner (
	input  logic                       data_clk_div,
	input  logic                       rst,
	input  logic                       align_en,
	input  adc_capture_pkg::raw_word_t frame_raw,
	output adc_capture_pkg::slip_t     slip,
	output logic                       frame_valid
);

	localparam int CNT_W = $clog2(adc_capture_pkg::LOCK_COUNT);

	adc_capture_pkg::align_state_t state;
	adc_capture_pkg::raw_word_t    frame_rot;
	logic [CNT_W-1:0]              match_cnt;
	logic                          match;

	assign frame_rot = adc_capture_pkg::rot_right(frame_raw, slip);
	assign match = (frame_rot == adc_capture_pkg::FRAME_PATTERN);

	always_ff @(posedge data_clk_div) begin
		if (rst) begin
			state <= adc_capture_pkg::SEARCH;
			slip <= '0;
			match_cnt <= '0;
		end else if (!align_en) begin
			// idle, keep the last slip
			state <= adc_capture_pkg::SEARCH;
			match_cnt <= '0;
		end else begin
			case (state)
				adc_capture_pkg::SEARCH: begin
					if (match) begin
						if (match_cnt == CNT_W'(adc_capture_pkg::LOCK_COUNT - 1)) begin
							state <= adc_capture_pkg::LOCKED;
						end else begin
							match_cnt <= match_cnt + 1'b1;
						end
					end else begin
						// try the next bit position, wraps at 8
						slip <= slip + 3'd1;
						match_cnt <= '0;
					end
				end
				adc_capture_pkg::LOCKED: begin
					if (!match) begin
						state <= adc_capture_pkg::SEARCH;
						match_cnt <= '0;
					end
				end
				default: begin
					state <= adc_capture_pkg::SEARCH;
					match_cnt <= '0;
				end
			endcase
		end
	end

	assign frame_valid = (state == adc_capture_pkg::LOCKED);

endmodule

// ==== rtl/adc_capture_top.sv ====
module adc_capture_top #(
	parameter int DEPTH_LOG2 = 10
) (
	input  logic                        data_clk_div,
	input  logic                        rst,
	input  adc_capture_pkg::raw_word_t  frame_raw,
	input  adc_capture_pkg::lane_pair_t adc0_raw,
	input  adc_capture_pkg::lane_pair_t adc1_raw,
	input  adc_capture_pkg::wb_req_t    wb_req,
	output adc_capture_pkg::wb_rsp_t    wb_rsp
);

	adc_capture_pkg::slip_t        slip;
	logic                          frame_valid;
	logic                          align_en;
	logic                          capture_en;
	logic                          capture_done;
	adc_capture_pkg::sample_t      ch0_sample;
	adc_capture_pkg::sample_t      ch1_sample;
	adc_capture_pkg::sample_pair_t mem_data;
	logic [DEPTH_LOG2-1:0]         mem_addr;

	frame_aligner aligner (
		.data_clk_div (data_clk_div),
		.rst          (rst),
		.align_en     (align_en),
		.frame_raw    (frame_raw),
		.slip         (slip),
		.frame_valid  (frame_valid)
	);

	// both channels use the slip found on the frame lane
	sample_lane lane0 (
		.data_clk_div (data_clk_div),
		.rst          (rst),
		.raw          (adc0_raw),
		.slip         (slip),
		.sample       (ch0_sample)
	);

	sample_lane lane1 (
		.data_clk_div (data_clk_div),
		.rst          (rst),
		.raw          (adc1_raw),
		.slip         (slip),
		.sample       (ch1_sample)
	);

	capture_buffer #(
		.DEPTH_LOG2 (DEPTH_LOG2)
	) capture (
		.data_clk_div (data_clk_div),
		.rst          (rst),
		.capture_en   (capture_en),
		.ch0          (ch0_sample),
		.ch1          (ch1_sample),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.capture_done (capture_done)
	);

	wb_ctrl #(
		.DEPTH_LOG2 (DEPTH_LOG2)
	) ctrl (
		.data_clk_div (data_clk_div),
		.rst          (rst),
		.wb_req       (wb_req),
		.wb_rsp       (wb_rsp),
		.slip         (slip),
		.frame_valid  (frame_valid),
		.capture_done (capture_done),
		.mem_data     (mem_data),
		.capture_en   (capture_en),
		.align_en     (align_en),
		.mem_addr     (mem_addr)
	);

endmodule

// ==== rtl/sample_lane.sv ====
module sample_lane (
	input  logic                        data_clk_div,
	input  logic                        rst,
	input  adc_capture_pkg::lane_pair_t raw,
	input  adc_capture_pkg::slip_t      slip,
	output adc_capture_pkg::sample_t    sample
);

	adc_capture_pkg::raw_word_t a_rot;
	adc_capture_pkg::raw_word_t b_rot;
	adc_capture_pkg::sample_t   merged;

	assign a_rot = adc_capture_pkg::rot_right(raw.lane_a, slip);
	assign b_rot = adc_capture_pkg::rot_right(raw.lane_b, slip);

	// lane a carries the odd bits, lane b the even bits
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			merged[2*i+1] = a_rot[i];
			merged[2*i] = b_rot[i];
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (rst) begin
			sample <= '0;
		end else begin
			sample <= merged;
		end
	end

endmodule

// ==== tb/adc_capture_asserts.sv ====
module adc_capture_asserts (
	input logic                     data_clk_div,
	input logic                     rst,
	input adc_capture_pkg::wb_req_t wb_req,
	input adc_capture_pkg::wb_rsp_t wb_rsp,
	input adc_capture_pkg::slip_t   slip,
	input logic                     frame_valid
);

	int fail_count = 0;

	ack_in_request: assert property (@(posedge data_clk_div) disable iff (rst)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
	else begin
		$error("ack seen without an active request");
		fail_count++;
	end

	ack_one_cycle: assert property (@(posedge data_clk_div) disable iff (rst)
		wb_rsp.ack |=> !wb_rsp.ack)
	else begin
		$error("ack held longer than one cycle");
		fail_count++;
	end

	// locked aligner must not move the slip
	slip_held: assert property (@(posedge data_clk_div) disable iff (rst)
		frame_valid |=> $stable(slip))
	else begin
		$error("slip changed while frame_valid was high");
		fail_count++;
	end

endmodule

bind wb_ctrl adc_capture_asserts bus_checks (
	.data_clk_div (data_clk_div),
	.rst          (rst),
	.wb_req       (wb_req),
	.wb_rsp       (wb_rsp),
	.slip         (slip),
	.frame_valid  (frame_valid)
);

// ==== tb/adc_checker.sv ====
module adc_checker (
	input logic                     data_clk_div,
	input logic                     rst,
	input adc_capture_pkg::wb_rsp_t wb_rsp
);

	int    errors = 0;
	int    tests = 0;
	int    errors_at_start = 0;
	int    acks = 0;
	string test_name = "";

	// bus activity, sampled away from the active edge
	always @(negedge data_clk_div) begin
		if (!rst && wb_rsp.ack) begin
			acks++;
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic check_value(input string name, input adc_capture_pkg::wb_data_t exp,
			input adc_capture_pkg::wb_data_t act);
		if (act !== exp) begin
			$display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_fail(input string what);
		$display("Error in %s: %s", test_name, what);
		errors++;
	endtask

	// one ack per bus cycle started, no spurious ones
	task automatic check_acks(input int expected);
		check_value("ack count", expected, acks);
	endtask

	task automatic end_test();
		tests++;
		if (errors == errors_at_start) begin
			$display("test %s: pass", test_name);
		end else begin
			$display("test %s: fail, %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic summary(input int assert_fails);
		$display("%0d tests, %0d check errors, %0d assertion failures, %0d bus acks",
			tests, errors, assert_fails, acks);
	endtask

endmodule

// ==== tb/tb_adc_capture.sv ====
module tb_adc_capture;

	localparam int DEPTH_LOG2 = 10;
	localparam int DEPTH = 2 ** DEPTH_LOG2;

	logic                          data_clk_div;
	logic                          rst;
	adc_capture_pkg::raw_word_t    frame_raw = '0;
	adc_capture_pkg::lane_pair_t   adc0_raw = '0;
	adc_capture_pkg::lane_pair_t   adc1_raw = '0;
	adc_capture_pkg::wb_req_t      wb_req;
	adc_capture_pkg::wb_rsp_t      wb_rsp;
	adc_capture_pkg::sample_pair_t history[$];
	adc_capture_pkg::wb_data_t     rd;
	int                            seed = 32'h26a4;
	int                            k;
	int                            start0;
	int                            start1;
	int                            addr;
	int                            bus_count = 0;

	adc_capture_top #(.DEPTH_LOG2(DEPTH_LOG2)) uut (.*);

	adc_checker chk (.data_clk_div(data_clk_div), .rst(rst), .wb_rsp(wb_rsp));

	initial begin
		data_clk_div = 1'b0;
		forever #50 data_clk_div = ~data_clk_div;
	end

	function automatic adc_capture_pkg::raw_word_t rot_left(adc_capture_pkg::raw_word_t w,
			int n);
		logic [15:0] dbl;
		dbl = {w, w} << n;
		return dbl[15:8];
	endfunction

	// lane a gets the odd sample bits, lane b the even ones, then skew by k
	function automatic adc_capture_pkg::lane_pair_t split_sample(adc_capture_pkg::sample_t s);
		adc_capture_pkg::lane_pair_t lp;
		for (int i = 0; i < 8; i++) begin
			lp.lane_a[i] = s[2*i+1];
			lp.lane_b[i] = s[2*i];
		end
		lp.lane_a = rot_left(lp.lane_a, k);
		lp.lane_b = rot_left(lp.lane_b, k);
		return lp;
	endfunction

	function automatic adc_capture_pkg::wb_addr_t mem_adr(int a);
		return adc_capture_pkg::wb_addr_t'((1 << adc_capture_pkg::MEM_SEL_BIT) | a);
	endfunction

	always @(negedge data_clk_div) begin
		adc_capture_pkg::sample_pair_t p;
		p = $random(seed);
		frame_raw = rot_left(adc_capture_pkg::FRAME_PATTERN, k);
		adc0_raw = split_sample(p.ch0);
		adc1_raw = split_sample(p.ch1);
		history.push_back(p);
	end

	task automatic finish_run();
		int errors;
		chk.check_acks(bus_count);
		errors = chk.errors + uut.ctrl.bus_checks.fail_count;
		chk.summary(uut.ctrl.bus_checks.fail_count);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	task automatic bus_cycle(input logic we, input adc_capture_pkg::wb_addr_t adr,
			input adc_capture_pkg::wb_data_t dat, output adc_capture_pkg::wb_data_t rdat);
		int n;
		rdat = '0;
		@(negedge data_clk_div);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		bus_count++;
		n = 0;
		do begin
			@(negedge data_clk_div);
			n++;
		end while (!wb_rsp.ack && n < 20);
		if (!wb_rsp.ack) begin
			chk.report_fail($sformatf("no ack for address 0x%h", adr));
		end else begin
			rdat = wb_rsp.dat;
		end
		// hold through the ack edge, then release
		@(negedge data_clk_div);
		wb_req = '0;
	endtask

	task automatic poll_status(input int bit_idx, output adc_capture_pkg::wb_data_t st);
		int n;
		n = 0;
		do begin
			bus_cycle(1'b0, adc_capture_pkg::REG_STATUS, '0, st);
			n++;
		end while (!st[bit_idx] && n < 2000);
		if (!st[bit_idx]) begin
			chk.report_fail($sformatf("status bit %0d never came up", bit_idx));
		end
	endtask

	task automatic apply_reset();
		@(negedge data_clk_div);
		rst = 1'b1;
		repeat (8) @(negedge data_clk_div);
		rst = 1'b0;
	endtask

	// new skew between posedges so the driver sees it cleanly
	task automatic new_offset();
		@(posedge data_clk_div);
		k = $random(seed) & 7;
		history.delete();
	endtask

	task automatic check_block(output int start);
		adc_capture_pkg::wb_data_t w;
		start = -1;
		for (int a = 0; a < DEPTH; a++) begin
			bus_cycle(1'b0, mem_adr(a), '0, w);
			if (a == 0) begin
				foreach (history[i]) begin
					if (start < 0 && history[i] == w) begin
						start = i;
					end
				end
				if (start < 0) begin
					chk.report_fail("first captured word is not in the sample history");
					return;
				end
			end else begin
				chk.check_value($sformatf("mem[%0d]", a), history[start+a], w);
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		k = 0;
		wb_req = '0;
		apply_reset();

		chk.start_test("reset values");
		bus_cycle(1'b0, adc_capture_pkg::REG_STATUS, '0, rd);
		chk.check_value("status", '0, rd);
		bus_cycle(1'b0, adc_capture_pkg::REG_CTRL, '0, rd);
		chk.check_value("ctrl", '0, rd);
		chk.end_test();

		chk.start_test("frame alignment");
		new_offset();
		bus_cycle(1'b1, adc_capture_pkg::REG_CTRL, 32'h2, rd);
		poll_status(4, rd);
		chk.check_value("status", 32'h10 | k, rd);
		bus_cycle(1'b1, adc_capture_pkg::REG_CTRL, 32'h0, rd);
		apply_reset();
		new_offset();
		bus_cycle(1'b1, adc_capture_pkg::REG_CTRL, 32'h2, rd);
		poll_status(4, rd);
		chk.check_value("status", 32'h10 | k, rd);
		chk.end_test();

		chk.start_test("block capture");
		bus_cycle(1'b1, adc_capture_pkg::REG_CTRL, 32'h3, rd);
		poll_status(5, rd);
		check_block(start0);
		chk.end_test();

		chk.start_test("capture restart");
		bus_cycle(1'b1, adc_capture_pkg::REG_CTRL, 32'h2, rd);
		bus_cycle(1'b0, adc_capture_pkg::REG_STATUS, '0, rd);
		chk.check_value("status", 32'h10 | k, rd);
		bus_cycle(1'b1, adc_capture_pkg::REG_CTRL, 32'h3, rd);
		poll_status(5, rd);
		check_block(start1);
		if (start1 < start0 + DEPTH) begin
			chk.report_fail("second block does not start after the first block");
		end
		chk.end_test();

		chk.start_test("memory write ignored");
		addr = $random(seed) & (DEPTH - 1);
		bus_cycle(1'b1, mem_adr(addr), $random(seed), rd);
		bus_cycle(1'b0, mem_adr(addr), '0, rd);
		chk.check_value($sformatf("mem[%0d]", addr), history[start1+addr], rd);
		chk.end_test();

		finish_run();
	end

endmodule
